/* logic/free_list.sv */
`timescale 1ns/1ps

module free_list #(
    parameter int PHYS_REG_BITS = rv32i_types::PHYS_REG_BITS_DEFAULT
) (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     alloc,
    output logic [PHYS_REG_BITS-1:0] free_preg,
    output logic                     fl_empty,
    input  logic                     commit_valid,
    input  logic [PHYS_REG_BITS-1:0] commit_preg
);

    // the first 32 physical registers back the reset identity map.
    localparam int NUM_FREE = (2 ** PHYS_REG_BITS) - 32;
    localparam int PTR_BITS = (NUM_FREE > 1) ? $clog2(NUM_FREE) : 1;
    localparam int CNT_BITS = $clog2(NUM_FREE + 1);

    typedef logic [PHYS_REG_BITS-1:0] preg_t;
    typedef logic [PTR_BITS-1:0]      ptr_t;
    typedef logic [CNT_BITS-1:0]      cnt_t;

    preg_t mem [NUM_FREE];
    ptr_t  head;
    ptr_t  tail;
    cnt_t  count;
    logic  push;
    logic  pop;

    function automatic ptr_t next_ptr(input ptr_t p);
        return (p == ptr_t'(NUM_FREE - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    assign fl_empty  = (count == '0);
    assign free_preg = mem[head];  // offered to dispatch before it is taken.
    assign pop       = alloc && !fl_empty;
    assign push      = commit_valid && (count != cnt_t'(NUM_FREE));

    //////////////////////////////////////////////////
    // storage and pointers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            // the list starts full with 32 and up in ascending order.
            for (int i = 0; i < NUM_FREE; i++) begin
                mem[i] <= preg_t'(32 + i);
            end
            head  <= '0;
            tail  <= '0;  // full, so the tail has wrapped onto the head.
            count <= cnt_t'(NUM_FREE);
        end else begin
            if (push) begin
                mem[tail] <= commit_preg;
                tail      <= next_ptr(tail);
            end
            if (pop) head <= next_ptr(head);
            case ({push, pop})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;
            endcase
        end
    end

endmodule : free_list

/* logic/inst_queue.sv */
`timescale 1ns/1ps

module inst_queue #(
    parameter int IQ_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    inst_valid,
    input  rv32i_types::inst_word_t inst,
    output logic                    inst_ready,
    input  logic                    dequeue,
    output rv32i_types::inst_word_t head_inst,
    output logic                    iq_empty
);

    localparam int PTR_BITS = (IQ_DEPTH > 1) ? $clog2(IQ_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(IQ_DEPTH + 1);

    typedef logic [PTR_BITS-1:0] ptr_t;
    typedef logic [CNT_BITS-1:0] cnt_t;

    rv32i_types::inst_word_t mem [IQ_DEPTH];
    ptr_t wr_ptr;
    ptr_t rd_ptr;
    cnt_t count;
    logic push;
    logic pop;

    // pointers wrap explicitly so the depth need not be a power of two.
    function automatic ptr_t next_ptr(input ptr_t p);
        return (p == ptr_t'(IQ_DEPTH - 1)) ? '0 : p + ptr_t'(1);
    endfunction

    assign inst_ready = (count != cnt_t'(IQ_DEPTH)); // full queue refuses the push.
    assign iq_empty   = (count == '0);
    assign push       = inst_valid && inst_ready;
    assign pop        = dequeue && !iq_empty;
    assign head_inst  = mem[rd_ptr];  // the head is read combinationally.

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= inst;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop) rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + cnt_t'(1);
                2'b01:   count <= count - cnt_t'(1);
                default: count <= count;  // both or neither leave the level unchanged.
            endcase
        end
    end

endmodule : inst_queue

/* logic/rat.sv */
`timescale 1ns/1ps

module rat #(
    parameter int PHYS_REG_BITS = rv32i_types::PHYS_REG_BITS_DEFAULT
) (
    input  logic                     clk,
    input  logic                     reset,

    // source lookup, answered in the same cycle.
    input  rv32i_types::arch_reg_t   rs1,
    input  rv32i_types::arch_reg_t   rs2,
    output logic [PHYS_REG_BITS-1:0] ps1,
    output logic [PHYS_REG_BITS-1:0] ps2,
    output logic                     ps1_valid,
    output logic                     ps2_valid,

    // destination rename.
    input  logic                     rat_we,
    input  rv32i_types::arch_reg_t   rd,
    input  logic [PHYS_REG_BITS-1:0] pd,

    // completion broadcast.
    input  logic                     cdb_valid,
    input  logic [PHYS_REG_BITS-1:0] cdb_preg
);

    localparam int NUM_PREGS = 2 ** PHYS_REG_BITS;

    typedef logic [PHYS_REG_BITS-1:0] preg_t;

    preg_t                map [32];
    logic [NUM_PREGS-1:0] ready;  // one bit per physical register.

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < 32; r++) begin
                map[r] <= preg_t'(r);
            end
            ready <= '1;
        end else begin
            if (cdb_valid) ready[cdb_preg] <= 1'b1;
            // r0 keeps physical 0 for good, so its map entry is never written.
            if (rat_we && (rd != '0)) begin
                map[rd]   <= pd;
                ready[pd] <= 1'b0;  // the new value is still in flight.
            end
        end
    end

    // reads see the old map, so a source equal to rd gets the previous producer.
    assign ps1 = map[rs1];
    assign ps2 = map[rs2];

    // a broadcast of the looked-up register counts as ready right away.
    assign ps1_valid = (rs1 == '0) || ready[ps1] || (cdb_valid && (cdb_preg == ps1));
    assign ps2_valid = (rs2 == '0) || ready[ps2] || (cdb_valid && (cdb_preg == ps2));

endmodule : rat

/* logic/rename_dispatch.sv */
`timescale 1ns/1ps

module rename_dispatch #(
    parameter int PHYS_REG_BITS = rv32i_types::PHYS_REG_BITS_DEFAULT
) (
    // instruction queue head.
    input  rv32i_types::inst_word_t   head_inst,
    input  logic                      iq_empty,
    output logic                      dequeue,

    // free list.
    input  logic [PHYS_REG_BITS-1:0]  free_preg,
    input  logic                      fl_empty,
    output logic                      alloc,

    // register alias table.
    output rv32i_types::arch_reg_t    rs1,
    output rv32i_types::arch_reg_t    rs2,
    input  logic [PHYS_REG_BITS-1:0]  ps1,
    input  logic [PHYS_REG_BITS-1:0]  ps2,
    input  logic                      ps1_valid,
    input  logic                      ps2_valid,
    output logic                      rat_we,
    output rv32i_types::arch_reg_t    rd,
    output logic [PHYS_REG_BITS-1:0]  pd,

    // back-pressure from the ROB and the stations.
    input  logic                      rob_full,
    input  logic                      rs_full_add,
    input  logic                      rs_full_mul,
    input  logic                      rs_full_div,
    input  logic [PHYS_REG_BITS-1:0]  rob_num,

    // dispatch packet.
    output logic                      dispatch_valid,
    output rv32i_types::rs_sel_t      rs_select,
    output rv32i_types::decode_info_t decode_info,
    output logic [PHYS_REG_BITS-1:0]  ps1_out,
    output logic [PHYS_REG_BITS-1:0]  ps2_out,
    output logic                      ps1_valid_out,
    output logic                      ps2_valid_out,
    output logic [PHYS_REG_BITS-1:0]  rob_num_out
);

    logic opcode_writes;  // the opcode has a destination register.
    logic writes_reg;
    logic station_full;
    logic fire;

    //////////////////////////////////////////////////
    // decode
    //////////////////////////////////////////////////

    always_comb begin
        decode_info.opcode = head_inst[6:0];
        decode_info.funct3 = head_inst[14:12];
        decode_info.funct7 = head_inst[31:25];
        decode_info.i_imm  = {{21{head_inst[31]}}, head_inst[30:20]};
        decode_info.s_imm  = {{21{head_inst[31]}}, head_inst[30:25], head_inst[11:7]};
        decode_info.b_imm  = {{20{head_inst[31]}}, head_inst[7], head_inst[30:25],
                              head_inst[11:8], 1'b0};
        decode_info.u_imm  = {head_inst[31:12], 12'h000};
        decode_info.j_imm  = {{12{head_inst[31]}}, head_inst[19:12], head_inst[20],
                              head_inst[30:21], 1'b0};
        decode_info.rd_s   = head_inst[11:7];
        decode_info.rs1_s  = head_inst[19:15];
        decode_info.rs2_s  = head_inst[24:20];
    end

    // only the M extension leaves the add station.
    always_comb begin
        rs_select = rv32i_types::rs_add;
        if ((decode_info.opcode == rv32i_types::op_reg) &&
            (decode_info.funct7 == rv32i_types::FUNCT7_MULDIV)) begin
            case (decode_info.funct3)
                rv32i_types::mult_div_f3_mul, rv32i_types::mult_div_f3_mulh,
                rv32i_types::mult_div_f3_mulhsu, rv32i_types::mult_div_f3_mulhu:
                    rs_select = rv32i_types::rs_mul;
                rv32i_types::mult_div_f3_div, rv32i_types::mult_div_f3_divu,
                rv32i_types::mult_div_f3_rem, rv32i_types::mult_div_f3_remu:
                    rs_select = rv32i_types::rs_div;
                default: rs_select = rv32i_types::rs_add;
            endcase
        end
    end

    always_comb begin
        case (decode_info.opcode)
            rv32i_types::op_lui, rv32i_types::op_auipc, rv32i_types::op_jal,
            rv32i_types::op_jalr, rv32i_types::op_load, rv32i_types::op_imm,
            rv32i_types::op_reg:                      opcode_writes = 1'b1;
            rv32i_types::op_br, rv32i_types::op_store: opcode_writes = 1'b0;
            default:                                  opcode_writes = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////
    // stall check and rename
    //////////////////////////////////////////////////

    always_comb begin
        case (rs_select)
            rv32i_types::rs_mul: station_full = rs_full_mul;
            rv32i_types::rs_div: station_full = rs_full_div;
            default:             station_full = rs_full_add;
        endcase
    end

    assign writes_reg = opcode_writes && (decode_info.rd_s != '0); // writes to r0 are dropped.

    // an empty free list only blocks instructions that need a new register.
    assign fire = !iq_empty && !rob_full && !station_full && (!writes_reg || !fl_empty);

    assign dequeue        = fire;
    assign dispatch_valid = fire;
    assign alloc          = fire && writes_reg;
    assign rat_we         = fire && writes_reg;

    assign rs1 = decode_info.rs1_s;
    assign rs2 = decode_info.rs2_s;
    assign rd  = decode_info.rd_s;
    assign pd  = writes_reg ? free_preg : '0;

    assign ps1_out       = ps1;
    assign ps2_out       = ps2;
    assign ps1_valid_out = ps1_valid;
    assign ps2_valid_out = ps2_valid;
    assign rob_num_out   = rob_num;  // the ROB slot travels with the packet.

endmodule : rename_dispatch

/* logic/rename_unit.sv */
`timescale 1ns/1ps

module rename_unit #(
    parameter int PHYS_REG_BITS = rv32i_types::PHYS_REG_BITS_DEFAULT,
    parameter int IQ_DEPTH      = 8
) (
    input  logic                      clk,
    input  logic                      reset,

    input  logic                      inst_valid,
    input  rv32i_types::inst_word_t   inst,
    output logic                      inst_ready,

    input  logic                      cdb_valid,
    input  logic [PHYS_REG_BITS-1:0]  cdb_preg,
    input  logic                      commit_valid,
    input  logic [PHYS_REG_BITS-1:0]  commit_preg,

    input  logic                      rob_full,
    input  logic                      rs_full_add,
    input  logic                      rs_full_mul,
    input  logic                      rs_full_div,
    input  logic [PHYS_REG_BITS-1:0]  rob_num,

    output logic                      dispatch_valid,
    output rv32i_types::rs_sel_t      rs_select,
    output rv32i_types::decode_info_t decode_info,
    output logic [PHYS_REG_BITS-1:0]  pd,
    output logic [PHYS_REG_BITS-1:0]  ps1,
    output logic [PHYS_REG_BITS-1:0]  ps2,
    output logic                      ps1_valid,
    output logic                      ps2_valid,
    output logic [PHYS_REG_BITS-1:0]  rob_num_out
);

    typedef logic [PHYS_REG_BITS-1:0] preg_t;

    // everything a station receives for one instruction.
    typedef struct packed {
        logic                      valid;
        rv32i_types::rs_sel_t      rs_select;
        rv32i_types::decode_info_t decode_info;
        preg_t                     pd;
        preg_t                     ps1;
        preg_t                     ps2;
        logic                      ps1_valid;
        logic                      ps2_valid;
        preg_t                     rob_num;
    } dispatch_pkt_t;

    wire dispatch_pkt_t       pkt;
    rv32i_types::inst_word_t  head_inst;
    logic                     iq_empty;
    logic                     dequeue;
    preg_t                    free_preg;
    logic                     fl_empty;
    logic                     alloc;
    rv32i_types::arch_reg_t   rs1;
    rv32i_types::arch_reg_t   rs2;
    rv32i_types::arch_reg_t   rd;
    preg_t                    rat_ps1;
    preg_t                    rat_ps2;
    logic                     rat_ps1_valid;
    logic                     rat_ps2_valid;
    logic                     rat_we;

    //////////////////////////////////////////////////
    // blocks
    //////////////////////////////////////////////////

    inst_queue #(.IQ_DEPTH(IQ_DEPTH)) inst_queue_inst (
        .clk, .reset, .inst_valid, .inst, .inst_ready,
        .dequeue, .head_inst, .iq_empty
    );

    free_list #(.PHYS_REG_BITS(PHYS_REG_BITS)) free_list_inst (
        .clk, .reset, .alloc, .free_preg, .fl_empty, .commit_valid, .commit_preg
    );

    rat #(.PHYS_REG_BITS(PHYS_REG_BITS)) rat_inst (
        .clk, .reset, .rs1, .rs2,
        .ps1(rat_ps1), .ps2(rat_ps2), .ps1_valid(rat_ps1_valid), .ps2_valid(rat_ps2_valid),
        .rat_we, .rd, .pd(pkt.pd), .cdb_valid, .cdb_preg
    );

    rename_dispatch #(.PHYS_REG_BITS(PHYS_REG_BITS)) rename_dispatch_inst (
        .head_inst, .iq_empty, .dequeue, .free_preg, .fl_empty, .alloc,
        .rs1, .rs2, .ps1(rat_ps1), .ps2(rat_ps2),
        .ps1_valid(rat_ps1_valid), .ps2_valid(rat_ps2_valid),
        .rat_we, .rd, .pd(pkt.pd),
        .rob_full, .rs_full_add, .rs_full_mul, .rs_full_div, .rob_num,
        .dispatch_valid(pkt.valid), .rs_select(pkt.rs_select),
        .decode_info(pkt.decode_info),
        .ps1_out(pkt.ps1), .ps2_out(pkt.ps2),
        .ps1_valid_out(pkt.ps1_valid), .ps2_valid_out(pkt.ps2_valid),
        .rob_num_out(pkt.rob_num)
    );

    // the packet leaves the unit as separate fields.
    assign dispatch_valid = pkt.valid;
    assign rs_select      = pkt.rs_select;
    assign decode_info    = pkt.decode_info;
    assign pd             = pkt.pd;
    assign ps1            = pkt.ps1;
    assign ps2            = pkt.ps2;
    assign ps1_valid      = pkt.ps1_valid;
    assign ps2_valid      = pkt.ps2_valid;
    assign rob_num_out    = pkt.rob_num;

endmodule : rename_unit

/* logic/rv32i_types.sv */
package rv32i_types;

    //////////////////////////////////////////////////
    // widths with a meaning of their own
    //////////////////////////////////////////////////

    typedef logic [4:0]  arch_reg_t;   // architectural register index.
    typedef logic [31:0] inst_word_t;  // raw fetched instruction.
    typedef logic [31:0] imm_t;        // immediate after sign extension.

    localparam int PHYS_REG_BITS_DEFAULT = 6;

    // funct7 that marks the M extension inside op_reg.
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

    //////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } rv32i_opcode_t;

    typedef enum logic [2:0] {
        mult_div_f3_mul    = 3'b000,
        mult_div_f3_mulh   = 3'b001,
        mult_div_f3_mulhsu = 3'b010,
        mult_div_f3_mulhu  = 3'b011,
        mult_div_f3_div    = 3'b100,
        mult_div_f3_divu   = 3'b101,
        mult_div_f3_rem    = 3'b110,
        mult_div_f3_remu   = 3'b111
    } mult_div_f3_t;

    // target reservation station of a dispatched instruction.
    typedef enum logic [1:0] {
        rs_add = 2'b00,
        rs_mul = 2'b01,
        rs_div = 2'b10
    } rs_sel_t;

    // every field the stations may need, decoded once at dispatch.
    typedef struct packed {
        logic [6:0] opcode;
        logic [2:0] funct3;
        logic [6:0] funct7;
        imm_t       i_imm;
        imm_t       s_imm;
        imm_t       b_imm;
        imm_t       u_imm;
        imm_t       j_imm;
        arch_reg_t  rd_s;
        arch_reg_t  rs1_s;
        arch_reg_t  rs2_s;
    } decode_info_t;

endpackage : rv32i_types

/* run_sim.sh */
#!/bin/sh
# Builds the rename unit testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing \
    --top-module tb_rename_unit \
    --Mdir "$BUILD_DIR" \
    -f sim.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/Vtb_rename_unit" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
exit 0

/* sim.f */
logic/rv32i_types.sv
logic/inst_queue.sv
logic/free_list.sv
logic/rat.sv
logic/rename_dispatch.sv
logic/rename_unit.sv
testbench/tb_rename_unit.sv

/* testbench/rename_testdata.txt */
# name push inst(hex) rob_full full_add full_mul full_div cdb_v cdb_preg commit_v commit_preg count
#   then expected: valid rs_sel pd ps1 ps2 ps1_valid ps2_valid rd_s i_imm(hex)
# first writers after reset take 32 and up, sources map to themselves.
alu_first          1 00510093 0 0 0 0 0 0  0 0  1  1 0 32  2  5 1 1  1 00000005
alu_second         1 fff20193 0 0 0 0 0 0  0 0  1  1 0 33  4 31 1 1  3 ffffffff
# station choice and per-station full flags.
mul_other_full     1 027302b3 0 1 0 1 0 0  0 0  1  1 1 34  6  7 1 1  5 00000027
div_own_full       1 02a4c433 0 0 0 1 0 0  0 0  1  0 2 35  9 10 1 1  8 0000002a
div_released       0 02a4c433 0 0 0 0 0 0  0 0  1  1 2 35  9 10 1 1  8 0000002a
rem_other_full     1 02d665b3 0 0 1 0 0 0  0 0  1  1 2 36 12 13 1 1 11 0000002d
mulhu_own_full     1 0230b733 0 0 1 0 0 0  0 0  1  0 1 37 32 33 0 0 14 00000023
# readers of renamed registers and the cdb.
mulhu_cdb_bypass   0 0230b733 0 0 0 0 1 33 0 0  1  1 1 37 32 33 0 1 14 00000023
add_after_cdb      1 001187b3 0 0 0 0 0 0  0 0  1  1 0 38 33 32 1 0 15 00000001
src_equals_rd      1 00108093 0 0 0 0 0 0  0 0  1  1 0 39 32 32 0 0  1 00000001
# no destination register means no allocation.
store_no_alloc     1 0057a423 0 0 0 0 0 0  0 0  1  1 0  0 38 34 0 0  8 00000005
branch_no_alloc    1 00018863 0 0 0 0 0 0  0 0  1  1 0  0 33  0 1 1 16 00000000
rd_zero_no_alloc   1 00710013 0 0 0 0 0 0  0 0  1  1 0  0  2  7 1 1  0 00000007
lui_next_pd        1 12345837 0 0 0 0 0 0  0 0  1  1 0 40 35 33 0 1 16 00000123
# rob back-pressure.
rob_full_stall     1 00a00893 1 0 0 0 0 0  0 0  1  0 0 41  0 10 1 1 17 0000000a
rob_full_release   0 00a00893 0 0 0 0 0 0  0 0  1  1 0 41  0 10 1 1 17 0000000a
# empty free list and its refill by a commit.
drain_free_list    1 00100913 0 0 0 0 0 0  0 0 22  1 0 42  0 39 1 0 18 00000001
store_list_empty   1 0057a423 0 0 0 0 0 0  0 0  1  1 0  0 38 34 0 0  8 00000005
free_list_stall    1 00310993 0 0 0 0 0 0  0 0  1  0 0 40  2 33 1 1 19 00000003
commit_40          0 00310993 0 0 0 0 0 0  1 40  1  0 0 40  2 33 1 1 19 00000003
commit_released    0 00310993 0 0 0 0 0 0  0 0  1  1 0 40  2 33 1 1 19 00000003

/* testbench/tb_rename_unit.sv */
`timescale 1ns/1ps

module tb_rename_unit;

    localparam int    PREG_BITS = 6;
    localparam int    IQ_DEPTH  = 8;
    localparam string DATA_FILE = "testbench/rename_testdata.txt";

    // each line of the testdata file holds the stimulus and then the expected packet.
    typedef struct packed {
        logic                 push;
        logic [31:0]          inst;
        logic                 rob_full;
        logic                 full_add;
        logic                 full_mul;
        logic                 full_div;
        logic                 cdb_valid;
        logic [PREG_BITS-1:0] cdb_preg;
        logic                 commit_valid;
        logic [PREG_BITS-1:0] commit_preg;
        logic [7:0]           count;          // how many times the line is run.
        logic                 exp_valid;
        logic [1:0]           exp_rs_sel;
        logic [PREG_BITS-1:0] exp_pd;
        logic [PREG_BITS-1:0] exp_ps1;
        logic [PREG_BITS-1:0] exp_ps2;
        logic                 exp_ps1_valid;
        logic                 exp_ps2_valid;
        logic [4:0]           exp_rd;
        logic [31:0]          exp_i_imm;
    } test_vec_t;

    logic                      clk;
    logic                      reset;
    logic                      inst_valid;
    rv32i_types::inst_word_t   inst;
    logic                      inst_ready;
    logic                      cdb_valid;
    logic [PREG_BITS-1:0]      cdb_preg;
    logic                      commit_valid;
    logic [PREG_BITS-1:0]      commit_preg;
    logic                      rob_full;
    logic                      rs_full_add;
    logic                      rs_full_mul;
    logic                      rs_full_div;
    logic [PREG_BITS-1:0]      rob_num;
    logic                      dispatch_valid;
    rv32i_types::rs_sel_t      rs_select;
    rv32i_types::decode_info_t decode_info;
    logic [PREG_BITS-1:0]      pd;
    logic [PREG_BITS-1:0]      ps1;
    logic [PREG_BITS-1:0]      ps2;
    logic                      ps1_valid;
    logic                      ps2_valid;
    logic [PREG_BITS-1:0]      rob_num_out;

    test_vec_t vecs [$];
    string     names [$];
    int        test_errors = 0;
    int        pass_count = 0;
    int        fail_count = 0;
    int        cycle_count = 0;
    int        cycle_limit = 100;

    rename_unit #(.PHYS_REG_BITS(PREG_BITS), .IQ_DEPTH(IQ_DEPTH)) rename_unit_inst (
        .clk, .reset, .inst_valid, .inst, .inst_ready,
        .cdb_valid, .cdb_preg, .commit_valid, .commit_preg,
        .rob_full, .rs_full_add, .rs_full_mul, .rs_full_div, .rob_num,
        .dispatch_valid, .rs_select, .decode_info, .pd, .ps1, .ps2,
        .ps1_valid, .ps2_valid, .rob_num_out
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic read_testdata(output bit ok);
        int        fd;
        int        n;
        int        v [20];
        string     line;
        string     name;
        test_vec_t t;
        ok = 1'b1;
        fd = $fopen(DATA_FILE, "r");
        if (fd == 0) begin
            $display("cannot open %s", DATA_FILE);
            ok = 1'b0;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line.getc(0) == "#") continue;  // blank or comment.
            n = $sscanf(line, "%s %d %h %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d %h",
                        name, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                        v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19]);
            if (n != 21) begin
                $display("malformed line in testdata file: %s", line);
                ok = 1'b0;
                continue;
            end
            t.push          = 1'(v[0]);
            t.inst          = 32'(v[1]);
            t.rob_full      = 1'(v[2]);
            t.full_add      = 1'(v[3]);
            t.full_mul      = 1'(v[4]);
            t.full_div      = 1'(v[5]);
            t.cdb_valid     = 1'(v[6]);
            t.cdb_preg      = PREG_BITS'(v[7]);
            t.commit_valid  = 1'(v[8]);
            t.commit_preg   = PREG_BITS'(v[9]);
            t.count         = 8'(v[10]);
            t.exp_valid     = 1'(v[11]);
            t.exp_rs_sel    = 2'(v[12]);
            t.exp_pd        = PREG_BITS'(v[13]);
            t.exp_ps1       = PREG_BITS'(v[14]);
            t.exp_ps2       = PREG_BITS'(v[15]);
            t.exp_ps1_valid = 1'(v[16]);
            t.exp_ps2_valid = 1'(v[17]);
            t.exp_rd        = 5'(v[18]);
            t.exp_i_imm     = 32'(v[19]);
            vecs.push_back(t);
            names.push_back(name);
        end
        $fclose(fd);
        if (vecs.size() == 0) begin
            $display("no tests found in %s", DATA_FILE);
            ok = 1'b0;
        end
    endtask

    task automatic check_value(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("** Error: %s %s expected %0h actual %0h", test, field, expected, actual);
            test_errors++;
        end
    endtask

    task automatic report_test(input string name);
        if (test_errors == 0) begin
            pass_count++;
            $display("%s: passed", name);
        end else begin
            fail_count++;
            $display("%s: failed with %0d mismatches", name, test_errors);
        end
    endtask

    // after reset the queue is empty and open for a push, and nothing dispatches.
    task automatic verify_reset_state();
        test_errors = 0;
        @(negedge clk);
        check_value("reset_state", "inst_ready", 32'(1'b1), 32'(inst_ready));
        check_value("reset_state", "dispatch_valid", 32'(1'b0), 32'(dispatch_valid));
        report_test("reset_state");
        @(posedge clk);
        #2;
    endtask

    // holds the word on the push port until the queue takes it.
    task automatic push_inst(input logic [31:0] word);
        inst_valid = 1'b1;
        inst       = word;
        @(negedge clk);
        while (!inst_ready) @(negedge clk);
        @(posedge clk);
        #2;
        inst_valid = 1'b0;
    endtask

    task automatic run_test(input int idx);
        test_vec_t            t;
        string                name;
        logic [PREG_BITS-1:0] exp_pd;
        t    = vecs[idx];
        name = names[idx];
        test_errors = 0;
        for (int rep = 0; rep < int'(t.count); rep++) begin
            if (t.push) push_inst(t.inst);
            rob_full     = t.rob_full;
            rs_full_add  = t.full_add;
            rs_full_mul  = t.full_mul;
            rs_full_div  = t.full_div;
            cdb_valid    = t.cdb_valid;
            cdb_preg     = t.cdb_preg;
            commit_valid = t.commit_valid;
            commit_preg  = t.commit_preg;
            rob_num      = PREG_BITS'(idx);
            // a repeated writer takes the next free register each time.
            exp_pd = (t.exp_pd == '0) ? '0 : t.exp_pd + PREG_BITS'(rep);
            @(negedge clk);
            check_value(name, "dispatch_valid", 32'(t.exp_valid), 32'(dispatch_valid));
            check_value(name, "rs_select", 32'(t.exp_rs_sel), 32'(rs_select));
            check_value(name, "rd_s", 32'(t.exp_rd), 32'(decode_info.rd_s));
            check_value(name, "i_imm", t.exp_i_imm, decode_info.i_imm);
            if (t.exp_valid) begin
                check_value(name, "pd", 32'(exp_pd), 32'(pd));
                check_value(name, "ps1", 32'(t.exp_ps1), 32'(ps1));
                check_value(name, "ps2", 32'(t.exp_ps2), 32'(ps2));
                check_value(name, "ps1_valid", 32'(t.exp_ps1_valid), 32'(ps1_valid));
                check_value(name, "ps2_valid", 32'(t.exp_ps2_valid), 32'(ps2_valid));
                check_value(name, "rob_num_out", 32'(PREG_BITS'(idx)), 32'(rob_num_out));
            end
            @(posedge clk);
            #2;
            cdb_valid    = 1'b0;  // broadcasts and commits last one edge.
            commit_valid = 1'b0;
        end
        report_test(name);
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////

    initial begin
        bit loaded;
        reset        = 1'b1;
        inst_valid   = 1'b0;
        inst         = '0;
        cdb_valid    = 1'b0;
        cdb_preg     = '0;
        commit_valid = 1'b0;
        commit_preg  = '0;
        rob_full     = 1'b0;
        rs_full_add  = 1'b0;
        rs_full_mul  = 1'b0;
        rs_full_div  = 1'b0;
        rob_num      = '0;
        read_testdata(loaded);
        cycle_limit = 40 * names.size() + 100;
        if (!loaded) begin
            $display("TEST FAIL");
        end else begin
            repeat (4) @(posedge clk);
            #2;
            reset = 1'b0;
            verify_reset_state();
            for (int i = 0; i < vecs.size(); i++) begin
                run_test(i);
            end
            $display("%0d tests passed, %0d tests failed", pass_count, fail_count);
            if (fail_count == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
        end
        $finish;
    end

endmodule : tb_rename_unit
